// File: design/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN        = 32;
  localparam int ADDER_WIDTH = XLEN + 1;
  localparam int TAG_WIDTH   = 4;

  typedef logic [XLEN-1:0]        exu_word_t;
  typedef logic [ADDER_WIDTH-1:0] exu_adder_t;
  typedef logic [TAG_WIDTH-1:0]   exu_tag_t;

  // Requestor class sharing the datapath
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_BJP,
    UNIT_AGU
  } exu_unit_e;

  typedef enum logic [4:0] {
    ADD, SUB, XOR, OR, AND,
    SLL, SRL, SRA,
    SLT, SLTU,
    LUI, SWAP,
    CMP_EQ, CMP_NE, CMP_LT, CMP_GT, CMP_LTU, CMP_GTU,
    MAX, MIN, MAXU, MINU,
    NOP
  } exu_func_e;

  // Status of the decode pipeline register
  typedef enum logic [1:0] {
    DEC_EMPTY,
    DEC_HOLD,
    DEC_RUN
  } dec_state_e;

  typedef struct packed {
    exu_unit_e unit;
    exu_func_e func;
    exu_word_t op1;
    exu_word_t op2;
    exu_tag_t  tag;
  } exu_cmd_t;

  typedef struct packed {
    logic op_add;
    logic op_sub;
    logic op_xor;
    logic op_or;
    logic op_and;
    logic op_sll;
    logic op_srl;
    logic op_sra;
    logic op_slt;
    logic op_sltu;
    logic op_mvop2;
    logic op_cmp_eq;
    logic op_cmp_ne;
    logic op_cmp_lt;
    logic op_cmp_gt;
    logic op_cmp_ltu;
    logic op_cmp_gtu;
    logic op_max;
    logic op_min;
    logic op_maxu;
    logic op_minu;
  } exu_ops_t;

  typedef struct packed {
    exu_ops_t  ops;
    exu_word_t op1;
    exu_word_t op2;
    exu_tag_t  tag;
    logic      illegal;
  } exu_dreq_t;

  typedef struct packed {
    exu_tag_t  tag;
    exu_word_t value;
    logic      cmp;
    logic      illegal;
  } exu_res_t;

endpackage

`default_nettype wire

// File: design/exu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module exu_decode #(
  parameter int CMD_DEPTH = 4
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cmd_valid,
  input  exu_pkg::exu_cmd_t  cmd,
  input  logic               advance,
  output logic               cmd_credit,
  output logic               dreq_valid,
  output exu_pkg::exu_dreq_t dreq
);
  import exu_pkg::*;

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  exu_cmd_t         queue_mem [CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic             q_empty;
  logic             pop;
  exu_cmd_t         head;
  exu_ops_t         head_ops;
  logic             head_legal;
  dec_state_e       state_q;
  dec_state_e       state_d;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign q_empty = (q_count == '0);
  assign head    = queue_mem[rd_ptr];
  // Head leaves the queue whenever the stage behind can move
  assign pop     = advance & ~q_empty;

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      queue_mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_count    <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({cmd_valid, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      // One credit back per popped entry
      cmd_credit <= pop;
    end
  end

  // One-hot flags from the function alone
  always_comb begin
    head_ops = '0;
    case (head.func)
      ADD:     head_ops.op_add     = 1'b1;
      SUB:     head_ops.op_sub     = 1'b1;
      XOR:     head_ops.op_xor     = 1'b1;
      OR:      head_ops.op_or      = 1'b1;
      AND:     head_ops.op_and     = 1'b1;
      SLL:     head_ops.op_sll     = 1'b1;
      SRL:     head_ops.op_srl     = 1'b1;
      SRA:     head_ops.op_sra     = 1'b1;
      SLT:     head_ops.op_slt     = 1'b1;
      SLTU:    head_ops.op_sltu    = 1'b1;
      LUI:     head_ops.op_mvop2   = 1'b1;
      SWAP:    head_ops.op_mvop2   = 1'b1;
      CMP_EQ:  head_ops.op_cmp_eq  = 1'b1;
      CMP_NE:  head_ops.op_cmp_ne  = 1'b1;
      CMP_LT:  head_ops.op_cmp_lt  = 1'b1;
      CMP_GT:  head_ops.op_cmp_gt  = 1'b1;
      CMP_LTU: head_ops.op_cmp_ltu = 1'b1;
      CMP_GTU: head_ops.op_cmp_gtu = 1'b1;
      MAX:     head_ops.op_max     = 1'b1;
      MIN:     head_ops.op_min     = 1'b1;
      MAXU:    head_ops.op_maxu    = 1'b1;
      MINU:    head_ops.op_minu    = 1'b1;
      default: head_ops = '0;
    endcase
  end

  // Which functions each requestor class may use
  always_comb begin
    case (head.unit)
      UNIT_ALU: head_legal = head.func inside {ADD, SUB, OR, XOR, AND, SLL, SRL, SRA,
                                               SLT, SLTU, LUI};
      UNIT_BJP: head_legal = head.func inside {ADD, CMP_EQ, CMP_NE, CMP_LT, CMP_GT,
                                               CMP_LTU, CMP_GTU};
      UNIT_AGU: head_legal = head.func inside {ADD, AND, OR, XOR, MAX, MIN, MAXU, MINU,
                                               SWAP};
      default:  head_legal = 1'b0;
    endcase
  end

  always_comb begin
    if (advance) begin
      state_d = q_empty ? DEC_EMPTY : DEC_RUN;
    end else if (state_q == DEC_EMPTY) begin
      state_d = DEC_EMPTY;
    end else begin
      // Output is stalled, keep the current request
      state_d = DEC_HOLD;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= DEC_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      dreq.ops     <= head_legal ? head_ops : '0;
      dreq.op1     <= head.op1;
      dreq.op2     <= head.op2;
      dreq.tag     <= head.tag;
      dreq.illegal <= ~head_legal;
    end
  end

  assign dreq_valid = (state_q != DEC_EMPTY);

endmodule

`default_nettype wire

// File: design/exu_alu_dpath.sv
`timescale 1ns/10ps
`default_nettype none

module exu_alu_dpath (
  input  exu_pkg::exu_dreq_t dreq,
  output exu_pkg::exu_word_t value,
  output logic               cmp
);
  import exu_pkg::*;

  exu_ops_t   ops;
  exu_word_t  op1;
  exu_word_t  op2;
  logic       op_shift;
  logic       op_right;
  exu_word_t  shifter_in1;
  logic [4:0] shifter_in2;
  exu_word_t  shifter_res;
  exu_word_t  sll_res;
  exu_word_t  srl_res;
  exu_word_t  sra_res;
  exu_word_t  eff_mask;
  logic       op_unsigned;
  logic       adder_sub;
  logic       adder_addsub;
  exu_adder_t adder_op1;
  exu_adder_t adder_op2;
  exu_adder_t adder_in1;
  exu_adder_t adder_in2;
  exu_adder_t adder_res;
  logic       adder_neg;
  logic       xorer_op;
  exu_word_t  xorer_res;
  exu_word_t  orer_res;
  exu_word_t  ander_res;
  logic       neq;
  logic       op_slttu;
  logic       op_maxmin;
  logic       maxmin_sel_op1;
  exu_word_t  slttu_res;
  exu_word_t  maxmin_res;

  function automatic exu_word_t rev_word(input exu_word_t w);
    exu_word_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = w[XLEN-1-i];
    end
    return r;
  endfunction

  assign ops = dreq.ops;
  assign op1 = dreq.op1;
  assign op2 = dreq.op2;

  // Single left shifter, right shifts go through bit reversal
  assign op_shift    = ops.op_sll | ops.op_srl | ops.op_sra;
  assign op_right    = ops.op_srl | ops.op_sra;
  assign shifter_in1 = {XLEN{op_shift}} & (op_right ? rev_word(op1) : op1);
  assign shifter_in2 = {5{op_shift}} & op2[4:0];
  assign shifter_res = shifter_in1 << shifter_in2;
  assign sll_res     = shifter_res;
  assign srl_res     = rev_word(shifter_res);
  // Vacated upper bits take the sign for sra
  assign eff_mask    = {XLEN{1'b1}} >> shifter_in2;
  assign sra_res     = (srl_res & eff_mask) | ({XLEN{op1[XLEN-1]}} & ~eff_mask);

  // 33-bit adder, also does every magnitude compare
  assign op_unsigned  = ops.op_sltu | ops.op_cmp_ltu | ops.op_cmp_gtu
                      | ops.op_maxu | ops.op_minu;
  assign adder_sub    = ops.op_sub
                      | ops.op_cmp_lt | ops.op_cmp_gt | ops.op_cmp_ltu | ops.op_cmp_gtu
                      | ops.op_max | ops.op_min | ops.op_maxu | ops.op_minu
                      | ops.op_slt | ops.op_sltu;
  assign adder_addsub = ops.op_add | adder_sub;
  assign adder_op1    = {{(ADDER_WIDTH-XLEN){~op_unsigned & op1[XLEN-1]}}, op1};
  assign adder_op2    = {{(ADDER_WIDTH-XLEN){~op_unsigned & op2[XLEN-1]}}, op2};
  assign adder_in1    = {ADDER_WIDTH{adder_addsub}} & adder_op1;
  assign adder_in2    = {ADDER_WIDTH{adder_addsub}} & (adder_sub ? ~adder_op2 : adder_op2);
  assign adder_res    = adder_in1 + adder_in2 + ADDER_WIDTH'(adder_sub);
  // Negative difference means op1 below op2
  assign adder_neg    = adder_res[XLEN];

  // XOR unit is shared with the equality compares
  assign xorer_op  = ops.op_xor | ops.op_cmp_eq | ops.op_cmp_ne;
  assign xorer_res = ({XLEN{xorer_op}} & op1) ^ ({XLEN{xorer_op}} & op2);
  assign orer_res  = op1 | op2;
  assign ander_res = op1 & op2;
  assign neq       = |xorer_res;

  // gt is really greater-or-equal, as a branch needs
  assign cmp = (ops.op_cmp_eq  & ~neq)
             | (ops.op_cmp_ne  &  neq)
             | (ops.op_cmp_lt  &  adder_neg)
             | (ops.op_cmp_ltu &  adder_neg)
             | (ops.op_cmp_gt  & ~adder_neg)
             | (ops.op_cmp_gtu & ~adder_neg);

  assign op_slttu       = ops.op_slt | ops.op_sltu;
  assign slttu_res      = {{(XLEN-1){1'b0}}, op_slttu & adder_neg};
  assign op_maxmin      = ops.op_max | ops.op_maxu | ops.op_min | ops.op_minu;
  assign maxmin_sel_op1 = ((ops.op_max | ops.op_maxu) & ~adder_neg)
                        | ((ops.op_min | ops.op_minu) &  adder_neg);
  assign maxmin_res     = maxmin_sel_op1 ? op1 : op2;

  // Flags are one-hot, so the gated results simply OR together
  assign value = ({XLEN{ops.op_or}}                 & orer_res)
               | ({XLEN{ops.op_and}}                & ander_res)
               | ({XLEN{ops.op_xor}}                & xorer_res)
               | ({XLEN{ops.op_add | ops.op_sub}}   & adder_res[XLEN-1:0])
               | ({XLEN{ops.op_sll}}                & sll_res)
               | ({XLEN{ops.op_srl}}                & srl_res)
               | ({XLEN{ops.op_sra}}                & sra_res)
               | ({XLEN{ops.op_mvop2}}              & op2)
               | ({XLEN{op_slttu}}                  & slttu_res)
               | ({XLEN{op_maxmin}}                 & maxmin_res);

endmodule

`default_nettype wire

// File: design/exu_result.sv
`timescale 1ns/10ps
`default_nettype none

module exu_result #(
  parameter int RES_CREDITS = 2
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               dreq_valid,
  input  exu_pkg::exu_dreq_t dreq,
  input  exu_pkg::exu_word_t value,
  input  logic               cmp,
  input  logic               res_credit,
  output logic               advance,
  output logic               res_valid,
  output exu_pkg::exu_res_t  res
);
  import exu_pkg::*;

  localparam int CW = $clog2(RES_CREDITS + 1);

  logic [CW-1:0] credit_cnt;
  logic          send;

  // Stall everything behind us when the consumer has no room
  assign advance = (credit_cnt != '0);
  assign send    = dreq_valid & advance;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CW'(RES_CREDITS);
      res_valid  <= 1'b0;
    end else begin
      case ({send, res_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      res_valid <= send;
    end
  end

  // Result payload, only meaningful with res_valid
  always_ff @(posedge clk) begin
    if (send) begin
      res.tag     <= dreq.tag;
      res.value   <= value;
      res.cmp     <= cmp;
      res.illegal <= dreq.illegal;
    end
  end

endmodule

`default_nettype wire

// File: design/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top #(
  parameter int CMD_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cmd_valid,
  input  exu_pkg::exu_cmd_t cmd,
  output logic              cmd_credit,
  output logic              res_valid,
  output exu_pkg::exu_res_t res,
  input  logic              res_credit
);
  import exu_pkg::*;

  logic      advance;
  logic      dreq_valid;
  exu_dreq_t dreq;
  exu_word_t dp_value;
  logic      dp_cmp;

  exu_decode #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .advance    (advance),
    .cmd_credit (cmd_credit),
    .dreq_valid (dreq_valid),
    .dreq       (dreq)
  );

  // Shared datapath, purely combinational
  exu_alu_dpath u_alu_dpath (
    .dreq  (dreq),
    .value (dp_value),
    .cmp   (dp_cmp)
  );

  exu_result #(
    .RES_CREDITS (RES_CREDITS)
  ) u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .dreq_valid (dreq_valid),
    .dreq       (dreq),
    .value      (dp_value),
    .cmp        (dp_cmp),
    .res_credit (res_credit),
    .advance    (advance),
    .res_valid  (res_valid),
    .res        (res)
  );

endmodule

`default_nettype wire

// File: test/tb_exu_model.svh
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

// Next value of the 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Which requestor classes may use a function
function automatic logic unit_accepts(input exu_unit_e u, input exu_func_e f);
  case (f)
    ADD:                             return u inside {UNIT_ALU, UNIT_BJP, UNIT_AGU};
    SUB, SLL, SRL, SRA, SLT, SLTU:   return u == UNIT_ALU;
    LUI:                             return u == UNIT_ALU;
    XOR, OR, AND:                    return (u == UNIT_ALU) || (u == UNIT_AGU);
    CMP_EQ, CMP_NE, CMP_LT, CMP_GT:  return u == UNIT_BJP;
    CMP_LTU, CMP_GTU:                return u == UNIT_BJP;
    MAX, MIN, MAXU, MINU, SWAP:      return u == UNIT_AGU;
    default:                         return 1'b0;
  endcase
endfunction

// Reference result of one command
function automatic exu_res_t expected_result(input exu_cmd_t c);
  exu_res_t          r;
  exu_word_t         a;
  exu_word_t         b;
  logic signed [XLEN-1:0] sa;
  logic signed [XLEN-1:0] sb;
  r     = '0;
  r.tag = c.tag;
  a     = c.op1;
  b     = c.op2;
  sa    = c.op1;
  sb    = c.op2;
  if (!unit_accepts(c.unit, c.func)) begin
    r.illegal = 1'b1;
    return r;
  end
  case (c.func)
    ADD:     r.value = a + b;
    SUB:     r.value = a - b;
    XOR:     r.value = a ^ b;
    OR:      r.value = a | b;
    AND:     r.value = a & b;
    SLL:     r.value = a << b[4:0];
    SRL:     r.value = a >> b[4:0];
    SRA:     r.value = sa >>> b[4:0];
    SLT:     r.value = (sa < sb) ? 32'd1 : 32'd0;
    SLTU:    r.value = (a < b) ? 32'd1 : 32'd0;
    LUI:     r.value = b;
    SWAP:    r.value = b;
    CMP_EQ:  r.cmp = (a == b);
    CMP_NE:  r.cmp = (a != b);
    CMP_LT:  r.cmp = (sa < sb);
    // Branch style, true on equal operands as well
    CMP_GT:  r.cmp = (sa >= sb);
    CMP_LTU: r.cmp = (a < b);
    CMP_GTU: r.cmp = (a >= b);
    MAX:     r.value = (sa >= sb) ? a : b;
    MIN:     r.value = (sa < sb) ? a : b;
    MAXU:    r.value = (a >= b) ? a : b;
    MINU:    r.value = (a < b) ? a : b;
    default: r.value = '0;
  endcase
  return r;
endfunction

task automatic check_word(input string name, input exu_word_t expected, input exu_word_t actual);
  if (expected !== actual) begin
    stop_with_failure($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (expected !== actual) begin
    stop_with_failure($sformatf("** Error %s: expected %b, actual %b", name, expected, actual));
  end
endtask

task automatic check_tag(input string name, input exu_tag_t expected, input exu_tag_t actual);
  if (expected !== actual) begin
    stop_with_failure($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
  end
endtask

`endif

// File: test/tb_exu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exu;
  import exu_pkg::*;

  localparam int CMD_DEPTH   = 4;
  localparam int RES_CREDITS = 2;
  localparam int WAIT_LIMIT  = 2000;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     cmd_valid;
  exu_cmd_t cmd;
  logic     cmd_credit;
  logic     res_valid;
  exu_res_t res;
  logic     res_credit;

  logic [31:0] rng_state   = 32'd96;
  logic [31:0] cons_state  = 32'd96;
  int          issue_credits = CMD_DEPTH;
  int          slots_held    = 0;
  int          results_seen  = 0;
  logic        hold_credits  = 1'b0;
  logic [6:0]  return_odds   = 7'd96;
  logic        stress_busy   = 1'b0;
  exu_tag_t    next_tag      = '0;
  string       test_name     = "reset";
  exu_res_t    expected_q[$];

  exu_func_e alu_funcs [11] = '{ADD, SUB, XOR, OR, AND, SLL, SRL, SRA, SLT, SLTU, LUI};
  exu_func_e bjp_funcs [7]  = '{ADD, CMP_EQ, CMP_NE, CMP_LT, CMP_GT, CMP_LTU, CMP_GTU};
  exu_func_e agu_funcs [9]  = '{ADD, AND, OR, XOR, MAX, MIN, MAXU, MINU, SWAP};

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  `include "tb_exu_model.svh"

  exu_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_credit (cmd_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] rand32();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // Boundary words show up often, the rest is random
  function automatic exu_word_t rand_operand();
    logic [31:0] r;
    r = rand32();
    case (r[31:29])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7fff_ffff;
      3'd3:    return 32'hffff_ffff;
      default: return rand32();
    endcase
  endfunction

  function automatic exu_func_e pick_func(input exu_unit_e u);
    logic [31:0] r;
    r = rand32();
    case (u)
      UNIT_ALU: return alu_funcs[r[31:16] % 11];
      UNIT_BJP: return bjp_funcs[r[31:16] % 7];
      default:  return agu_funcs[r[31:16] % 9];
    endcase
  endfunction

  // Entered and left 2 ns after a rising edge
  task automatic issue(input exu_cmd_t c);
    int waited;
    waited = 0;
    while (issue_credits == 0) begin
      cmd_valid = 1'b0;
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure("Issuer timed out waiting for an input credit");
      end
    end
    cmd_valid = 1'b1;
    cmd       = c;
    issue_credits--;
    expected_q.push_back(expected_result(c));
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic issue_random(input exu_unit_e u, input exu_func_e f);
    exu_cmd_t    c;
    logic [31:0] r;
    c.unit = u;
    c.func = f;
    c.op1  = rand_operand();
    c.op2  = rand_operand();
    r      = rand32();
    // Equal operands for the compares and max/min
    if (r[31:30] == 2'b00) begin
      c.op2 = c.op1;
    end
    c.tag = next_tag;
    next_tag++;
    issue(c);
  endtask

  task automatic issue_mixed();
    exu_unit_e u;
    u = exu_unit_e'(rand32() % 3);
    issue_random(u, pick_func(u));
  endtask

  task automatic issue_illegal();
    logic [31:0] r;
    exu_unit_e   u;
    exu_func_e   f;
    int          tries;
    tries = 0;
    do begin
      r = rand32();
      u = exu_unit_e'(r[31:30]);
      f = exu_func_e'(r[29:25]);
      tries++;
    end while (unit_accepts(u, f) && tries < 100);
    issue_random(u, f);
  endtask

  task automatic run_unit(input string name, input exu_unit_e u, input int count);
    test_name = name;
    for (int i = 0; i < count; i++) begin
      issue_random(u, pick_func(u));
    end
    wait_drain();
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_LIMIT) begin
        stop_with_failure($sformatf("%s: %0d results never arrived", test_name,
                                    expected_q.size()));
      end
    end
  endtask

  task automatic take_result();
    exu_res_t exp;
    if (expected_q.size() == 0) begin
      stop_with_failure("res_valid pulsed with no command outstanding");
    end else if (slots_held >= RES_CREDITS) begin
      stop_with_failure("res_valid pulsed while the consumer had no free slot");
    end else begin
      exp = expected_q.pop_front();
      check_tag({test_name, " tag"}, exp.tag, res.tag);
      check_word({test_name, " value"}, exp.value, res.value);
      check_bit({test_name, " cmp"}, exp.cmp, res.cmp);
      check_bit({test_name, " illegal"}, exp.illegal, res.illegal);
      slots_held++;
      results_seen++;
    end
  endtask

  // Outputs are sampled on the falling edge, away from the DUT's updates
  always @(negedge clk) begin
    if (arst_n) begin
      if (cmd_credit) begin
        if (issue_credits >= CMD_DEPTH) begin
          stop_with_failure("cmd_credit returned a credit that was never spent");
        end else begin
          issue_credits++;
        end
      end
      if (res_valid) begin
        take_result();
      end
    end
  end

  // Consumer frees result slots after a random delay
  initial begin
    res_credit = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      cons_state = lcg_next(cons_state);
      res_credit = 1'b0;
      if (!hold_credits && slots_held > 0 && cons_state[31:25] < return_odds) begin
        res_credit = 1'b1;
        slots_held--;
      end
    end
  end

  initial begin
    int issued;
    int guard;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;

    test_name = "credits after reset";
    @(negedge clk);
    check_bit("res_valid after reset", 1'b0, res_valid);
    check_bit("cmd_credit after reset", 1'b0, cmd_credit);
    @(posedge clk);
    #2;
    hold_credits = 1'b1;
    issued       = 0;
    while (issue_credits > 0 && issued < 4 * CMD_DEPTH) begin
      issue_mixed();
      issued++;
    end
    repeat (10) @(posedge clk);
    #2;
    // Queue entries, the decode register and the free result slots
    check_word("commands accepted with consumer held",
               exu_word_t'(CMD_DEPTH + 1 + RES_CREDITS), exu_word_t'(issued));
    check_word("input credits left", '0, exu_word_t'(issue_credits));
    check_word("results with consumer held", exu_word_t'(RES_CREDITS),
               exu_word_t'(results_seen));
    hold_credits = 1'b0;
    wait_drain();

    run_unit("alu random", UNIT_ALU, 200);
    run_unit("bjp random", UNIT_BJP, 150);
    run_unit("agu random", UNIT_AGU, 150);

    test_name = "illegal pairings";
    for (int i = 0; i < 60; i++) begin
      issue_illegal();
    end
    wait_drain();

    test_name   = "stalled consumer";
    return_odds = 7'd12;
    stress_busy = 1'b1;
    guard       = 0;
    fork
      begin
        for (int i = 0; i < 80; i++) begin
          issue_mixed();
        end
        stress_busy = 1'b0;
      end
      begin
        while (stress_busy && guard < WAIT_LIMIT) begin
          hold_credits = 1'b1;
          repeat (30) @(posedge clk);
          hold_credits = 1'b0;
          repeat (6) @(posedge clk);
          guard++;
        end
      end
    join
    hold_credits = 1'b0;
    return_odds  = 7'd96;
    wait_drain();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
design/exu_pkg.sv
design/exu_decode.sv
design/exu_alu_dpath.sv
design/exu_result.sv
design/exu_top.sv
test/tb_exu.sv
